// ==== shell_pkg.sv ====
package shell_pkg;

	// Host download side
	localparam int BYTE_W    = 8;
	localparam int INDEX_W   = 8;
	localparam int IOCTL_AW  = 25;

	// SDRAM write port
	localparam int ROM_WORD_W = 2 * BYTE_W;
	localparam int SDRAM_AW   = 24;
	localparam int BE_W       = ROM_WORD_W / BYTE_W;

	typedef logic [BYTE_W-1:0]     byte_t;
	typedef logic [INDEX_W-1:0]    ioctl_index_t;
	typedef logic [IOCTL_AW-1:0]   ioctl_addr_t;
	typedef logic [ROM_WORD_W-1:0] rom_word_t;
	typedef logic [SDRAM_AW-1:0]   sdram_waddr_t;

	// Bit 0 enables the low byte
	typedef logic [BE_W-1:0]       byte_en_t;

	// Index the host uses for the game ROM image
	localparam ioctl_index_t ROM_INDEX = 8'h00;

endpackage

// ==== rom_byte_if.sv ====
`timescale 1ns/100ps

interface rom_byte_if;
	import shell_pkg::*;

	logic  valid;
	byte_t data;
	// End of ROM download, never on a transfer cycle
	logic  last;
	logic  ready;

	modport source (
		output valid,
		output data,
		output last,
		input  ready
	);

	modport sink (
		input  valid,
		input  data,
		input  last,
		output ready
	);

endinterface

// ==== download_ctrl.sv ====
`timescale 1ns/100ps

module download_ctrl (
	input  logic                    CLK_40M,
	input  logic                    arst_n_i,
	input  logic                    ioctl_download_i,
	input  shell_pkg::ioctl_index_t ioctl_index_i,
	input  logic                    ioctl_wr_i,
	input  shell_pkg::byte_t        ioctl_dout_i,
	input  logic                    reset_req_i,
	output logic                    ioctl_wait_o,
	output logic                    rom_loaded_o,
	output logic                    core_reset_o,
	rom_byte_if.source              rom_bytes
);
	import shell_pkg::*;

	logic rom_dl;
	logic rom_dl_q;
	logic rom_wr;
	logic dl_end;
	logic end_pend;
	logic byte_held;

	assign rom_dl = ioctl_download_i && (ioctl_index_i == ROM_INDEX);
	assign rom_wr = rom_dl && ioctl_wr_i;

	// Falling edge of a ROM download, or one still waiting on the last byte
	assign dl_end = (rom_dl_q && !rom_dl) || end_pend;
	assign byte_held = rom_bytes.valid && !rom_bytes.ready;

	assign ioctl_wait_o = !rom_bytes.ready;

	always_ff @(posedge CLK_40M or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rom_dl_q        <= 1'b0;
			end_pend        <= 1'b0;
			rom_bytes.valid <= 1'b0;
			rom_bytes.last  <= 1'b0;
			rom_loaded_o    <= 1'b0;
		end else begin
			rom_dl_q <= rom_dl;

			if (rom_wr)
				rom_bytes.valid <= 1'b1;
			else if (rom_bytes.ready)
				rom_bytes.valid <= 1'b0;

			// Hold off last until the final byte has gone
			rom_bytes.last <= dl_end && !byte_held;
			end_pend       <= dl_end && byte_held;

			if (rom_dl && !rom_dl_q)
				rom_loaded_o <= 1'b0;
			else if (dl_end && !byte_held)
				rom_loaded_o <= 1'b1;
		end
	end

	always_ff @(posedge CLK_40M) begin
		if (rom_wr)
			rom_bytes.data <= ioctl_dout_i;
	end

	// Core stays in reset until a ROM image is in place
	always_ff @(posedge CLK_40M or negedge arst_n_i) begin
		if (!arst_n_i)
			core_reset_o <= 1'b1;
		else
			core_reset_o <= reset_req_i || !rom_loaded_o;
	end

endmodule

// ==== rom_loader.sv ====
`timescale 1ns/100ps

module rom_loader (
	input  logic                    CLK_40M,
	input  logic                    arst_n_i,
	rom_byte_if.sink                rom_bytes,
	output logic                    sdr_req_o,
	input  logic                    sdr_ack_i,
	output shell_pkg::sdram_waddr_t sdr_addr_o,
	output shell_pkg::rom_word_t    sdr_data_o,
	output shell_pkg::byte_en_t     sdr_be_o
);
	import shell_pkg::*;

	localparam byte_en_t BE_FULL = 2'b11;
	localparam byte_en_t BE_LOW  = 2'b01;

	byte_t        lo_byte;
	sdram_waddr_t word_addr;
	logic         odd_pend;
	logic         flush_pend;
	logic         byte_xfer;
	logic         word_go;
	logic         flush_go;

	assign byte_xfer = rom_bytes.valid && rom_bytes.ready;

	// Second byte of a pair completes a word
	assign word_go = byte_xfer && odd_pend;

	// Odd trailing byte goes out once the port is free
	assign flush_go = (rom_bytes.last || flush_pend) && odd_pend && !sdr_req_o;

	// One word held plus one byte pending is the most we buffer
	assign rom_bytes.ready = !((sdr_req_o && odd_pend) || flush_pend);

	always_ff @(posedge CLK_40M or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sdr_req_o  <= 1'b0;
			odd_pend   <= 1'b0;
			flush_pend <= 1'b0;
			word_addr  <= '0;
		end else begin
			if (word_go || flush_go)
				sdr_req_o <= 1'b1;
			else if (sdr_ack_i)
				sdr_req_o <= 1'b0;

			if (byte_xfer)
				odd_pend <= !odd_pend;
			else if (flush_go)
				odd_pend <= 1'b0;

			if (flush_go)
				flush_pend <= 1'b0;
			else if (rom_bytes.last && odd_pend)
				flush_pend <= 1'b1;

			// Next download starts again at word 0
			if (word_go)
				word_addr <= word_addr + 1'b1;
			else if (flush_go || (rom_bytes.last && !odd_pend))
				word_addr <= '0;
		end
	end

	always_ff @(posedge CLK_40M) begin
		if (byte_xfer && !odd_pend)
			lo_byte <= rom_bytes.data;

		if (word_go) begin
			sdr_data_o <= {rom_bytes.data, lo_byte};
			sdr_be_o   <= BE_FULL;
			sdr_addr_o <= word_addr;
		end else if (flush_go) begin
			sdr_data_o <= {8'h00, lo_byte};
			sdr_be_o   <= BE_LOW;
			sdr_addr_o <= word_addr;
		end
	end

endmodule

// ==== sigma_delta_dac.sv ====
`timescale 1ns/100ps

module sigma_delta_dac #(
	parameter int DAC_BITS = 16
) (
	input  logic                       CLK_40M,
	input  logic                       arst_n_i,
	input  logic signed [DAC_BITS-1:0] sample_i,
	output logic                       dac_o
);

	logic [DAC_BITS-1:0] offset_bin;
	logic [DAC_BITS:0]   acc_q;

	// Flip the sign bit, two's complement to offset binary
	assign offset_bin = {~sample_i[DAC_BITS-1], sample_i[DAC_BITS-2:0]};

	// Carry of the running sum is the pulse-density bit
	always_ff @(posedge CLK_40M or negedge arst_n_i) begin
		if (!arst_n_i)
			acc_q <= '0;
		else
			acc_q <= {1'b0, acc_q[DAC_BITS-1:0]} + {1'b0, offset_bin};
	end

	assign dac_o = acc_q[DAC_BITS];

endmodule

// ==== m92_shell_top.sv ====
`timescale 1ns/100ps

module m92_shell_top #(
	parameter int DAC_BITS = 16
) (
	input  logic                       CLK_40M,
	input  logic                       arst_n_i,

	input  logic                       ioctl_download_i,
	input  shell_pkg::ioctl_index_t    ioctl_index_i,
	input  logic                       ioctl_wr_i,
	input  shell_pkg::ioctl_addr_t     ioctl_addr_i,
	input  shell_pkg::byte_t           ioctl_dout_i,
	output logic                       ioctl_wait_o,

	input  logic                       reset_req_i,
	output logic                       rom_loaded_o,
	output logic                       core_reset_o,

	output logic                       sdr_req_o,
	input  logic                       sdr_ack_i,
	output shell_pkg::sdram_waddr_t    sdr_addr_o,
	output shell_pkg::rom_word_t       sdr_data_o,
	output shell_pkg::byte_en_t        sdr_be_o,

	input  logic signed [DAC_BITS-1:0] audio_l_i,
	input  logic signed [DAC_BITS-1:0] audio_r_i,
	output logic                       audio_l_o,
	output logic                       audio_r_o
);

	// ioctl_addr_i is not decoded, the loader keeps its own word count
	rom_byte_if rom_bytes ();

	download_ctrl u_download_ctrl (
		.CLK_40M          (CLK_40M),
		.arst_n_i         (arst_n_i),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.reset_req_i      (reset_req_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.rom_loaded_o     (rom_loaded_o),
		.core_reset_o     (core_reset_o),
		.rom_bytes        (rom_bytes.source)
	);

	rom_loader u_rom_loader (
		.CLK_40M    (CLK_40M),
		.arst_n_i   (arst_n_i),
		.rom_bytes  (rom_bytes.sink),
		.sdr_req_o  (sdr_req_o),
		.sdr_ack_i  (sdr_ack_i),
		.sdr_addr_o (sdr_addr_o),
		.sdr_data_o (sdr_data_o),
		.sdr_be_o   (sdr_be_o)
	);

	sigma_delta_dac #(
		.DAC_BITS (DAC_BITS)
	) dac_left (
		.CLK_40M  (CLK_40M),
		.arst_n_i (arst_n_i),
		.sample_i (audio_l_i),
		.dac_o    (audio_l_o)
	);

	sigma_delta_dac #(
		.DAC_BITS (DAC_BITS)
	) dac_right (
		.CLK_40M  (CLK_40M),
		.arst_n_i (arst_n_i),
		.sample_i (audio_r_i),
		.dac_o    (audio_r_o)
	);

endmodule

// ==== tb_m92_shell_props.sv ====
`timescale 1ns/100ps

module sdram_port_checks (
	input logic                    CLK_40M,
	input logic                    arst_n_i,
	input logic                    sdr_req_o,
	input logic                    sdr_ack_i,
	input shell_pkg::sdram_waddr_t sdr_addr_o,
	input shell_pkg::rom_word_t    sdr_data_o,
	input shell_pkg::byte_en_t     sdr_be_o
);

	// Word stays put until the SDRAM side takes it
	hold_until_ack: assert property (@(posedge CLK_40M) disable iff (!arst_n_i)
		(sdr_req_o && !sdr_ack_i) |=>
			($stable(sdr_addr_o) && $stable(sdr_data_o) && $stable(sdr_be_o)))
		else $error("SDRAM write port changed before the ack");

	req_low_in_reset: assert property (@(posedge CLK_40M)
		!arst_n_i |-> !sdr_req_o)
		else $error("sdr_req_o high while in reset");

	// A request with no byte enabled would write nothing
	be_not_empty: assert property (@(posedge CLK_40M) disable iff (!arst_n_i)
		sdr_req_o |-> (sdr_be_o != 2'b00))
		else $error("sdr_be_o is 00 during a request");

endmodule

bind rom_loader sdram_port_checks u_sdram_port_checks (
	.CLK_40M    (CLK_40M),
	.arst_n_i   (arst_n_i),
	.sdr_req_o  (sdr_req_o),
	.sdr_ack_i  (sdr_ack_i),
	.sdr_addr_o (sdr_addr_o),
	.sdr_data_o (sdr_data_o),
	.sdr_be_o   (sdr_be_o)
);

// ==== tb_m92_shell.sv ====
`timescale 1ns/100ps

module tb_m92_shell;
	import shell_pkg::*;

	localparam int DAC_BITS     = 8;
	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DLY    = 2;
	localparam int RESET_CYCLES = 3;

	localparam int EVEN_BYTES  = 32;
	localparam int ODD_BYTES   = 7;
	localparam int OTHER_BYTES = 8;
	localparam int PULSE_BYTES = 4;
	localparam int TOTAL_BYTES = EVEN_BYTES + ODD_BYTES + OTHER_BYTES + PULSE_BYTES;

	localparam int DAC_WINDOW = 256;
	localparam int DAC_LEVELS = 5;

	// Worst case per byte covers a 3 cycle ack delay plus back-pressure
	localparam int CYCLES_PER_BYTE = 12;
	localparam int WATCHDOG_CYCLES = TOTAL_BYTES * CYCLES_PER_BYTE
		+ DAC_LEVELS * (DAC_WINDOW + 4) + 400;

	localparam int ACK_TAB_LEN = 64;

	logic                       CLK_40M;
	logic                       arst_n_i;
	logic                       ioctl_download_i;
	ioctl_index_t               ioctl_index_i;
	logic                       ioctl_wr_i;
	ioctl_addr_t                ioctl_addr_i;
	byte_t                      ioctl_dout_i;
	logic                       ioctl_wait_o;
	logic                       reset_req_i;
	logic                       rom_loaded_o;
	logic                       core_reset_o;
	logic                       sdr_req_o;
	logic                       sdr_ack_i;
	sdram_waddr_t               sdr_addr_o;
	rom_word_t                  sdr_data_o;
	byte_en_t                   sdr_be_o;
	logic signed [DAC_BITS-1:0] audio_l_i;
	logic signed [DAC_BITS-1:0] audio_r_i;
	logic                       audio_l_o;
	logic                       audio_r_o;

	integer seed;
	int     ack_mask;
	int     ack_dly_tab[ACK_TAB_LEN];
	int     exp_rd;

	// Reference words in the order the loader must write them
	sdram_waddr_t exp_addr_q[$];
	rom_word_t    exp_data_q[$];
	byte_en_t     exp_be_q[$];

	m92_shell_top #(
		.DAC_BITS (DAC_BITS)
	) uut (
		.CLK_40M          (CLK_40M),
		.arst_n_i         (arst_n_i),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.reset_req_i      (reset_req_i),
		.rom_loaded_o     (rom_loaded_o),
		.core_reset_o     (core_reset_o),
		.sdr_req_o        (sdr_req_o),
		.sdr_ack_i        (sdr_ack_i),
		.sdr_addr_o       (sdr_addr_o),
		.sdr_data_o       (sdr_data_o),
		.sdr_be_o         (sdr_be_o),
		.audio_l_i        (audio_l_i),
		.audio_r_i        (audio_r_i),
		.audio_l_o        (audio_l_o),
		.audio_r_o        (audio_r_o)
	);

	initial begin
		CLK_40M = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_40M = ~CLK_40M;
	end

	task automatic stop_on_failure();
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic next_cycle();
		@(posedge CLK_40M);
		#DRIVE_DLY;
	endtask

	task automatic expect_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	// Even byte low, odd byte high, trailing byte alone with enables 01
	task automatic queue_expected_words(input byte_t bytes[$]);
		int n;
		n = bytes.size();
		for (int i = 0; i + 1 < n; i += 2) begin
			exp_addr_q.push_back(sdram_waddr_t'(i / 2));
			exp_data_q.push_back({bytes[i+1], bytes[i]});
			exp_be_q.push_back(2'b11);
		end
		if (n % 2 == 1) begin
			exp_addr_q.push_back(sdram_waddr_t'(n / 2));
			exp_data_q.push_back({8'h00, bytes[n-1]});
			exp_be_q.push_back(2'b01);
		end
	endtask

	task automatic host_download(input ioctl_index_t index, input byte_t bytes[$]);
		int k;
		k = 0;
		ioctl_index_i    = index;
		ioctl_download_i = 1'b1;
		next_cycle();
		while (k < bytes.size()) begin
			if (!ioctl_wait_o) begin
				ioctl_wr_i   = 1'b1;
				ioctl_dout_i = bytes[k];
				ioctl_addr_i = ioctl_addr_t'(k);
				k++;
			end else begin
				ioctl_wr_i = 1'b0;
			end
			next_cycle();
		end
		ioctl_wr_i = 1'b0;
		// Final byte must be accepted before the flag drops
		while (ioctl_wait_o)
			next_cycle();
		ioctl_download_i = 1'b0;
	endtask

	task automatic wait_words_drained();
		next_cycle();
		next_cycle();
		while (exp_rd < exp_addr_q.size() || sdr_req_o)
			next_cycle();
	endtask

	task automatic check_sdram_word();
		assert (exp_rd < exp_addr_q.size()) else begin
			$display("SDRAM write to address %h arrived when no word was expected",
				sdr_addr_o);
			stop_on_failure();
		end
		compare_value("sdr_addr_o", 32'(sdr_addr_o), 32'(exp_addr_q[exp_rd]));
		compare_value("sdr_data_o", 32'(sdr_data_o), 32'(exp_data_q[exp_rd]));
		compare_value("sdr_be_o", 32'(sdr_be_o), 32'(exp_be_q[exp_rd]));
		exp_rd++;
	endtask

	// SDRAM side, acks each request after a table driven delay
	initial begin : sdram_responder
		int   ack_cnt;
		logic waiting;
		sdr_ack_i = 1'b0;
		exp_rd    = 0;
		ack_cnt   = 0;
		waiting   = 1'b0;
		forever begin
			next_cycle();
			if (sdr_ack_i) begin
				sdr_ack_i = 1'b0;
			end else if (sdr_req_o) begin
				if (!waiting) begin
					waiting = 1'b1;
					ack_cnt = ack_dly_tab[exp_rd % ACK_TAB_LEN] & ack_mask;
				end
				if (ack_cnt == 0) begin
					check_sdram_word();
					sdr_ack_i = 1'b1;
					waiting   = 1'b0;
				end else begin
					ack_cnt--;
				end
			end
		end
	end

	task automatic check_reset_state();
		expect_bit("core_reset_o", core_reset_o, 1'b1);
		expect_bit("rom_loaded_o", rom_loaded_o, 1'b0);
		expect_bit("sdr_req_o", sdr_req_o, 1'b0);
		expect_bit("ioctl_wait_o", ioctl_wait_o, 1'b0);
		expect_bit("audio_l_o", audio_l_o, 1'b0);
		expect_bit("audio_r_o", audio_r_o, 1'b0);
	endtask

	task automatic ignore_other_index();
		byte_t bytes[$];
		for (int i = 0; i < OTHER_BYTES; i++)
			bytes.push_back(byte_t'($random(seed)));
		ack_mask = 3;
		host_download(8'hFF, bytes);
		repeat (8) begin
			next_cycle();
			expect_bit("sdr_req_o", sdr_req_o, 1'b0);
		end
		expect_bit("rom_loaded_o", rom_loaded_o, 1'b0);
		expect_bit("core_reset_o", core_reset_o, 1'b1);
	endtask

	task automatic load_even_rom();
		byte_t bytes[$];
		for (int i = 0; i < EVEN_BYTES; i++)
			bytes.push_back(byte_t'($random(seed)));
		ack_mask = 3;
		queue_expected_words(bytes);
		host_download(ROM_INDEX, bytes);
		wait_words_drained();
		expect_bit("rom_loaded_o", rom_loaded_o, 1'b1);
	endtask

	task automatic load_odd_rom();
		byte_t bytes[$];
		for (int i = 0; i < ODD_BYTES; i++)
			bytes.push_back(byte_t'($random(seed)));
		ack_mask = 3;
		queue_expected_words(bytes);
		host_download(ROM_INDEX, bytes);
		wait_words_drained();
		expect_bit("rom_loaded_o", rom_loaded_o, 1'b1);
	endtask

	task automatic time_core_reset();
		byte_t bytes[$];
		for (int i = 0; i < PULSE_BYTES; i++)
			bytes.push_back(byte_t'($random(seed)));
		ack_mask = 0;
		queue_expected_words(bytes);
		host_download(ROM_INDEX, bytes);
		// Download flag went low at this drive point
		expect_bit("core_reset_o", core_reset_o, 1'b1);
		next_cycle();
		expect_bit("rom_loaded_o", rom_loaded_o, 1'b1);
		expect_bit("core_reset_o", core_reset_o, 1'b1);
		next_cycle();
		expect_bit("core_reset_o", core_reset_o, 1'b0);
		wait_words_drained();

		reset_req_i = 1'b1;
		next_cycle();
		expect_bit("core_reset_o", core_reset_o, 1'b1);
		repeat (4) begin
			next_cycle();
			expect_bit("core_reset_o", core_reset_o, 1'b1);
		end
		reset_req_i = 1'b0;
		next_cycle();
		expect_bit("core_reset_o", core_reset_o, 1'b0);
	endtask

	// Ones over a full window equal the offset binary level
	task automatic run_dac_level(input logic signed [DAC_BITS-1:0] left,
			input logic signed [DAC_BITS-1:0] right);
		int ones_l;
		int ones_r;
		int exp_l;
		int exp_r;
		ones_l = 0;
		ones_r = 0;
		exp_l  = int'(left) + (1 << (DAC_BITS - 1));
		exp_r  = int'(right) + (1 << (DAC_BITS - 1));
		audio_l_i = left;
		audio_r_i = right;
		for (int i = 0; i < DAC_WINDOW; i++) begin
			next_cycle();
			ones_l += int'(audio_l_o);
			ones_r += int'(audio_r_o);
		end
		compare_value("audio_l_o ones", 32'(ones_l), 32'(exp_l));
		compare_value("audio_r_o ones", 32'(ones_r), 32'(exp_r));
	endtask

	task automatic measure_dac_density();
		int r;
		run_dac_level(8'sh00, 8'sh00);
		run_dac_level(8'sh7f, 8'sh80);
		run_dac_level(8'sh80, 8'sh7f);
		run_dac_level(8'sh01, 8'shff);
		r = $random(seed);
		run_dac_level(r[DAC_BITS-1:0], r[2*DAC_BITS-1:DAC_BITS]);
	endtask

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles, the tests did not complete", WATCHDOG_CYCLES);
		stop_on_failure();
	end

	initial begin : main_sequence
		seed             = 32'h84f9_5345;
		ack_mask         = 0;
		arst_n_i         = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = ROM_INDEX;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_dout_i     = '0;
		reset_req_i      = 1'b0;
		audio_l_i        = '0;
		audio_r_i        = '0;
		for (int i = 0; i < ACK_TAB_LEN; i++)
			ack_dly_tab[i] = $random(seed) & 3;

		repeat (RESET_CYCLES) @(posedge CLK_40M);
		#DRIVE_DLY;
		arst_n_i = 1'b1;

		check_reset_state();
		ignore_other_index();
		load_even_rom();
		load_odd_rom();
		time_core_reset();
		measure_dac_density();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
shell_pkg.sv
rom_byte_if.sv
download_ctrl.sv
rom_loader.sv
sigma_delta_dac.sv
m92_shell_top.sv
tb_m92_shell_props.sv
tb_m92_shell.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_m92_shell
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation PASSED
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

SOURCES    := $(shell cat $(FILELIST))
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
